//--- tb.f
+incdir+verif
common/conv_pkg.sv
common/line_ctrl_if.sv
conv_core/conv_line_buffer.sv
conv_core/conv_pe.sv
hw/conv_weight_loader.sv
hw/conv_sequencer.sv
hw/conv_top.sv
verif/tb_conv_top.sv

//--- verif/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

typedef pixel_t [PIC_SIZE*PIC_SIZE-1:0] image_t;    // Raster order, pixel 0 top left

// Numerical Recipes constants, full 32-bit period
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Correlation over the 5x5 neighbourhood of (r, c), zero outside the image
function automatic result_t conv_ref(input image_t img, input weights_t w,
                                     input int r, input int c);
    result_t acc;
    int      pr;
    int      pc;
    acc = '0;
    for (int i = 0; i < KERNEL_SIZE; i++) begin
        for (int j = 0; j < KERNEL_SIZE; j++) begin
            pr = r + i - PAD;                        // Image row under tap
            pc = c + j - PAD;                        // Image column under tap
            if (pr >= 0 && pr < PIC_SIZE && pc >= 0 && pc < PIC_SIZE) begin
                acc = acc + result_t'(img[pr * PIC_SIZE + pc])
                          * result_t'(w[i * KERNEL_SIZE + j]);
            end
        end
    end
    return acc;
endfunction

// In-image rows (or columns) covered by the kernel centred on p
function automatic int span_in_image(input int p);
    int n;
    n = 0;
    for (int k = -PAD; k <= PAD; k++) begin
        if (p + k >= 0 && p + k < PIC_SIZE) begin
            n++;
        end
    end
    return n;
endfunction

`endif

//--- verif/tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top import conv_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;
    localparam int          NPIX         = PIC_SIZE * PIC_SIZE;
    localparam int          NUM_FRAMES   = 4;
    localparam int          FRAME_CYCLES = KERNEL_TAPS + NPIX * 4 + 100;
    localparam logic [31:0] SEED         = 32'hb243_011b;

    `include "conv_model.svh"

    logic      clk;
    logic      rst_n;
    logic      conv_start;
    pixel_t    pic;
    logic      pic_valid;
    logic      need_pic;
    logic      weight_rd;
    waddr_t    weight_addr;
    weight_t   weight_data;
    logic      weight_data_valid;
    logic      conv_result_valid;
    result_t   conv_result;
    res_addr_t conv_result_addr;
    logic      conv_finish;

    image_t      image;                    // Frame being fed
    weights_t    kernel;                   // Contents of the weight memory
    result_t     expected [NPIX];          // Reference results by address
    logic [31:0] stim_state;               // LCG for images and weights
    logic [31:0] gap_state;                // LCG for pic_valid gaps
    logic        gap_mode;                 // Random stalls on the pixel strobe
    int          pix_idx;                  // Next pixel to offer
    int          res_count;                // Results seen this frame
    int          finish_count;             // conv_finish pulses this frame

    conv_top uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .conv_start        (conv_start),
        .pic               (pic),
        .pic_valid         (pic_valid),
        .need_pic          (need_pic),
        .weight_rd         (weight_rd),
        .weight_addr       (weight_addr),
        .weight_data       (weight_data),
        .weight_data_valid (weight_data_valid),
        .conv_result_valid (conv_result_valid),
        .conv_result       (conv_result),
        .conv_result_addr  (conv_result_addr),
        .conv_finish       (conv_finish)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t ns: %s = %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input res_addr_t got, input res_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t ns: %s = %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // Weight memory with one cycle read latency
    always @(posedge clk) begin
        if (!rst_n) begin
            weight_data_valid <= 1'b0;
        end else begin
            weight_data_valid <= weight_rd;
            weight_data       <= kernel[weight_addr];
        end
    end

    // Pixel source holds each pixel until need_pic takes it
    always @(posedge clk) begin : pixel_feed
        int next_idx;
        next_idx = pix_idx;
        if (conv_start) begin
            next_idx = 0;                          // New frame restarts the image
        end else if (pic_valid && need_pic) begin
            next_idx = pix_idx + 1;                // Taken on this edge
        end
        gap_state = lcg_next(gap_state);
        pix_idx   <= next_idx;
        pic_valid <= (next_idx < NPIX) && (!gap_mode || gap_state[31:30] != 2'b00);
        pic       <= (next_idx < NPIX) ? image[next_idx] : '0;
    end

    // Result monitor expects raster order
    always @(posedge clk) begin
        if (conv_start) begin
            res_count    <= 0;
            finish_count <= 0;
        end else if (rst_n) begin
            if (conv_result_valid) begin
                if (res_count >= NPIX) begin
                    abort_run("Result valid after the last address of the frame");
                end else begin
                    check_addr("conv_result_addr", conv_result_addr, res_addr_t'(res_count));
                    check_result("conv_result", conv_result, expected[res_count]);
                    res_count <= res_count + 1;
                end
            end
            if (conv_finish) begin
                if (res_count != NPIX) begin
                    abort_run("conv_finish pulsed before all results of the frame");
                end else begin
                    finish_count <= finish_count + 1;
                end
            end
        end
    end

    task automatic run_frame(input logic gaps);
        @(posedge clk);
        gap_mode   <= gaps;
        conv_start <= 1'b1;
        @(posedge clk);
        conv_start <= 1'b0;
        @(posedge clk);                            // Monitor counters cleared by now
        while (finish_count == 0) begin
            @(posedge clk);
        end
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (need_pic || weight_rd || conv_result_valid || conv_finish) begin
                abort_run("DUT still active after conv_finish");
            end
        end
        if (finish_count != 1 || res_count != NPIX || pix_idx != NPIX) begin
            abort_run($sformatf("Frame ended with %0d results, %0d pixels, %0d finish pulses",
                                res_count, pix_idx, finish_count));
        end
    endtask

    task automatic image_from_lcg();
        for (int i = 0; i < NPIX; i++) begin
            stim_state = lcg_next(stim_state);
            image[i]   = stim_state[31:24];
        end
    endtask

    task automatic kernel_from_lcg();
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            stim_state = lcg_next(stim_state);
            kernel[k]  = stim_state[31:24];
        end
    endtask

    task automatic model_expected();
        for (int r = 0; r < PIC_SIZE; r++) begin
            for (int c = 0; c < PIC_SIZE; c++) begin
                expected[r * PIC_SIZE + c] = conv_ref(image, kernel, r, c);
            end
        end
    endtask

    // All ones make each result the count of in-image pixels
    task automatic ones_frame();
        for (int i = 0; i < NPIX; i++) begin
            image[i] = 8'd1;
        end
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            kernel[k] = 8'd1;
        end
        for (int r = 0; r < PIC_SIZE; r++) begin
            for (int c = 0; c < PIC_SIZE; c++) begin
                expected[r * PIC_SIZE + c] = result_t'(span_in_image(r) * span_in_image(c));
            end
        end
        run_frame(1'b0);
    endtask

    task automatic random_frame();
        image_from_lcg();
        kernel_from_lcg();
        model_expected();
        run_frame(1'b0);
    endtask

    // Reuses the image, kernel and expected results of random_frame
    task automatic gapped_frame();
        run_frame(1'b1);
    endtask

    task automatic reload_frame();
        kernel_from_lcg();
        model_expected();
        run_frame(1'b1);
    endtask

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        conv_start        = 1'b0;
        pic               = '0;
        pic_valid         = 1'b0;
        weight_data       = '0;
        weight_data_valid = 1'b0;
        gap_mode          = 1'b0;
        stim_state        = SEED;
        gap_state         = lcg_next(SEED);        // Separate stream for stalls
        pix_idx           = NPIX;                  // Nothing offered before a frame
        res_count         = 0;
        finish_count      = 0;
        image             = '0;
        kernel            = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (need_pic || weight_rd || conv_result_valid || conv_finish) begin
            abort_run("DUT outputs not idle after reset");
        end
        ones_frame();
        random_frame();
        gapped_frame();
        reload_frame();
        $display("All tests passed!");
        $finish;
    end

    initial begin
        repeat (NUM_FRAMES * FRAME_CYCLES) @(posedge clk);
        abort_run("Watchdog timeout, a frame did not finish in time");
    end

endmodule

`default_nettype wire

//--- hw/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      conv_start,
    input  pixel_t    pic,
    input  logic      pic_valid,
    output logic      need_pic,
    output logic      weight_rd,
    output waddr_t    weight_addr,
    input  weight_t   weight_data,
    input  logic      weight_data_valid,
    output logic      conv_result_valid,
    output result_t   conv_result,
    output res_addr_t conv_result_addr,
    output logic      conv_finish
);

    line_ctrl_if lb_if ();               // Sequencer to line buffer control

    logic     load;                      // Kernel fetch request
    logic     loaded;                    // All taps stored
    logic     win_valid;                 // Window presented to the PE
    weights_t weights;
    window_t  window;

    conv_sequencer u_seq (
        .clk              (clk),
        .rst_n            (rst_n),
        .conv_start       (conv_start),
        .lb               (lb_if.seq),
        .load             (load),
        .loaded           (loaded),
        .win_valid        (win_valid),
        .res_valid        (conv_result_valid),
        .conv_result_addr (conv_result_addr),
        .conv_finish      (conv_finish)
    );

    conv_weight_loader u_wload (
        .clk               (clk),
        .rst_n             (rst_n),
        .load              (load),
        .weight_rd         (weight_rd),
        .weight_addr       (weight_addr),
        .weight_data       (weight_data),
        .weight_data_valid (weight_data_valid),
        .weights           (weights),
        .loaded            (loaded)
    );

    conv_line_buffer u_lbuf (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctl       (lb_if.lbuf),
        .pic       (pic),
        .pic_valid (pic_valid),
        .need_pic  (need_pic),
        .window    (window)
    );

    conv_pe u_pe (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (win_valid),
        .window       (window),
        .weights      (weights),
        .result       (conv_result),
        .result_valid (conv_result_valid)
    );

endmodule

`default_nettype wire

//--- hw/conv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      conv_start,
    line_ctrl_if.seq  lb,
    output logic      load,
    input  logic      loaded,
    output logic      win_valid,
    input  logic      res_valid,
    output res_addr_t conv_result_addr,
    output logic      conv_finish
);

    typedef enum logic [1:0] {IDLE, LOAD, FILL, CAL} state_t;

    state_t    state;
    col_t      res_col;                     // Column of the next returning result
    res_addr_t res_addr;                    // Raster address of the next result

    assign conv_result_addr = res_addr;     // Lines up with res_valid

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            load        <= 1'b0;
            lb.fill     <= 1'b0;
            lb.col      <= '0;
            win_valid   <= 1'b0;
            res_col     <= '0;
            res_addr    <= '0;
            conv_finish <= 1'b0;
        end else begin
            load        <= 1'b0;            // Single cycle pulses
            lb.fill     <= 1'b0;
            conv_finish <= 1'b0;
            case (state)
                IDLE: begin
                    if (conv_start) begin
                        load     <= 1'b1;   // Fetch kernel first
                        res_addr <= '0;
                        res_col  <= '0;
                        state    <= LOAD;
                    end
                end
                LOAD: begin
                    if (loaded) begin
                        lb.fill <= 1'b1;    // First fill of the frame
                        state   <= FILL;
                    end
                end
                FILL: begin
                    if (lb.row_ready) begin
                        lb.col    <= '0;
                        win_valid <= 1'b1;  // Windows go out back to back
                        state     <= CAL;
                    end
                end
                CAL: begin
                    if (win_valid) begin
                        if (lb.col == col_t'(PIC_SIZE - 1)) begin
                            win_valid <= 1'b0;
                        end else begin
                            lb.col <= lb.col + col_t'(1);
                        end
                    end
                    // Row is done only when its last result is back
                    if (res_valid) begin
                        res_addr <= res_addr + res_addr_t'(1);
                        if (res_col == col_t'(PIC_SIZE - 1)) begin
                            res_col <= '0;
                            if (lb.last_row) begin
                                conv_finish <= 1'b1;
                                state       <= IDLE;
                            end else begin
                                lb.fill <= 1'b1;
                                state   <= FILL;
                            end
                        end else begin
                            res_col <= res_col + col_t'(1);
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // A window takes two cycles through the PE, so no fill in that span
    assert property (@(posedge clk) disable iff (!rst_n)
        win_valid |-> (!lb.fill) [*3]);

    // PE results only come back during a compute row
    assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> state == CAL);

endmodule

`default_nettype wire

//--- hw/conv_weight_loader.sv
`timescale 1ns/1ps
`default_nettype none

module conv_weight_loader import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    output logic     weight_rd,
    output waddr_t   weight_addr,
    input  weight_t  weight_data,
    input  logic     weight_data_valid,
    output weights_t weights,
    output logic     loaded
);

    waddr_t tap;                             // Next tap to be written
    logic   taps_full;                       // Kernel complete since last load

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_rd   <= 1'b0;
            weight_addr <= '0;
            tap         <= '0;
            taps_full   <= 1'b0;
            loaded      <= 1'b0;
        end else begin
            loaded <= 1'b0;
            // Read side, one address per cycle
            if (load) begin
                weight_rd   <= 1'b1;
                weight_addr <= '0;
                tap         <= '0;
                taps_full   <= 1'b0;
            end else if (weight_rd) begin
                if (weight_addr == waddr_t'(KERNEL_TAPS - 1)) begin
                    weight_rd <= 1'b0;       // Last address issued
                end else begin
                    weight_addr <= weight_addr + waddr_t'(1);
                end
            end
            // Return side, latency is up to the memory
            if (weight_data_valid) begin
                if (tap == waddr_t'(KERNEL_TAPS - 1)) begin
                    tap       <= '0;
                    taps_full <= 1'b1;
                    loaded    <= 1'b1;
                end else begin
                    tap <= tap + waddr_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (weight_data_valid) begin
            weights[tap] <= weight_data;     // Fills in address order
        end
    end

    // Memory must return exactly one word per read
    assert property (@(posedge clk) disable iff (!rst_n)
        weight_data_valid |-> !taps_full);

endmodule

`default_nettype wire

//--- conv_core/conv_pe.sv
`timescale 1ns/1ps
`default_nettype none

module conv_pe import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  window_t  window,
    input  weights_t weights,
    output result_t  result,
    output logic     result_valid
);

    typedef logic [PIXEL_BITS+WEIGHT_BITS-1:0] prod_t;

    prod_t [KERNEL_TAPS-1:0] prod;           // Stage 1 products
    logic                    prod_valid;
    result_t                 sum;            // Adder tree, full precision

    // Stage 1, one multiplier per tap
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int k = 0; k < KERNEL_TAPS; k++) begin
                prod[k] <= window[k] * weights[k];
            end
        end
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            sum = sum + result_t'(prod[k]);
        end
    end

    // Stage 2 holds the sum
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            result <= sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            prod_valid   <= in_valid;        // No stall, one item per cycle
            result_valid <= prod_valid;
        end
    end

endmodule

`default_nettype wire

//--- conv_core/conv_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_line_buffer import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    line_ctrl_if.lbuf ctl,
    input  pixel_t    pic,
    input  logic      pic_valid,
    output logic      need_pic,
    output window_t   window
);

    typedef logic [$clog2(KERNEL_SIZE)-1:0] brow_t;   // Buffer row index
    typedef logic [$clog2(PIC_SIZE)-1:0]    orow_t;   // Output row index
    typedef logic [$clog2(PIC_SIZE + 1)-1:0] irow_t;  // Image rows taken

    pixel_t rows [KERNEL_SIZE][ROW_WIDTH];  // Row 0 is the top of the window
    orow_t  out_row;                        // Output row now prepared
    irow_t  img_row;                        // Image rows loaded this frame
    brow_t  wr_row;                         // Buffer row being loaded
    col_t   wr_col;                         // Image column being loaded
    logic   first_fill;
    logic   take;

    // Wraps after the last row, so the next fill starts a new frame
    assign first_fill   = ctl.fill && (out_row == orow_t'(PIC_SIZE - 1));
    assign take         = need_pic && pic_valid;
    assign ctl.last_row = (out_row == orow_t'(PIC_SIZE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_row       <= orow_t'(PIC_SIZE - 1);
            img_row       <= '0;
            wr_row        <= '0;
            wr_col        <= '0;
            need_pic      <= 1'b0;
            ctl.row_ready <= 1'b0;
        end else begin
            ctl.row_ready <= 1'b0;
            if (ctl.fill) begin
                out_row <= first_fill ? '0 : out_row + orow_t'(1);
                wr_col  <= '0;
                if (first_fill) begin
                    img_row  <= '0;
                    wr_row   <= brow_t'(PAD);             // Top PAD rows stay zero
                    need_pic <= 1'b1;
                end else if (img_row < irow_t'(PIC_SIZE)) begin
                    wr_row   <= brow_t'(KERNEL_SIZE - 1); // One new bottom row
                    need_pic <= 1'b1;
                end else begin
                    ctl.row_ready <= 1'b1;                // Bottom padding needs only a shift
                end
            end
            if (take) begin
                if (wr_col == col_t'(PIC_SIZE - 1)) begin
                    wr_col  <= '0;
                    img_row <= img_row + irow_t'(1);
                    if (wr_row == brow_t'(KERNEL_SIZE - 1)) begin
                        need_pic      <= 1'b0;
                        ctl.row_ready <= 1'b1;
                    end else begin
                        wr_row <= wr_row + brow_t'(1);
                    end
                end else begin
                    wr_col <= wr_col + col_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (first_fill) begin
            for (int i = 0; i < KERNEL_SIZE; i++) begin
                for (int j = 0; j < ROW_WIDTH; j++) begin
                    rows[i][j] <= '0;                     // Clears borders too
                end
            end
        end else if (ctl.fill) begin
            for (int i = 0; i < KERNEL_SIZE - 1; i++) begin
                rows[i] <= rows[i + 1];                   // Shift up one row
            end
            for (int j = 0; j < ROW_WIDTH; j++) begin
                rows[KERNEL_SIZE - 1][j] <= '0;
            end
        end
        if (take) begin
            rows[wr_row][PAD + int'(wr_col)] <= pic;      // Interior only
        end
    end

    always_comb begin
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            for (int j = 0; j < KERNEL_SIZE; j++) begin
                window[i * KERNEL_SIZE + j] = rows[i][int'(ctl.col) + j];
            end
        end
    end

    // Intake must be idle before the sequencer asks for another row
    assert property (@(posedge clk) disable iff (!rst_n)
        ctl.fill |-> !need_pic);

    // No pixel is accepted while need_pic is low
    assert property (@(posedge clk) disable iff (!rst_n)
        !need_pic && !ctl.fill |=> $stable(wr_col) && $stable(wr_row) && $stable(img_row));

endmodule

`default_nettype wire

//--- common/line_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_ctrl_if import conv_pkg::*; ();

    logic fill;       // Pulse, prepare the next output row
    logic row_ready;  // Pulse, rows in place for windowing
    logic last_row;   // Prepared row is the final output row
    col_t col;        // Window column

    // Sequencer side
    modport seq (
        output fill,
        output col,
        input  row_ready,
        input  last_row
    );

    // Line buffer side
    modport lbuf (
        input  fill,
        input  col,
        output row_ready,
        output last_row
    );

endinterface

`default_nettype wire

//--- common/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int PIXEL_BITS  = 8;                        // Unsigned pixel width
    localparam int WEIGHT_BITS = 8;                        // Unsigned weight width
    localparam int KERNEL_SIZE = 5;                        // Kernel side length
    localparam int PAD         = KERNEL_SIZE / 2;          // Zero border on each side
    localparam int PIC_SIZE    = 8;                        // Image width and height
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;
    localparam int ROW_WIDTH   = PIC_SIZE + 2 * PAD;       // Padded row length

    // Largest single product, all taps at full scale set the result width
    localparam int MAX_PRODUCT = (2 ** PIXEL_BITS - 1) * (2 ** WEIGHT_BITS - 1);
    localparam int RESULT_BITS = $clog2(KERNEL_TAPS * MAX_PRODUCT + 1); // 21 bits

    typedef logic [PIXEL_BITS-1:0]  pixel_t;
    typedef logic [WEIGHT_BITS-1:0] weight_t;
    typedef logic [RESULT_BITS-1:0] result_t;

    typedef pixel_t  [KERNEL_TAPS-1:0] window_t;           // Row major, tap 0 top left
    typedef weight_t [KERNEL_TAPS-1:0] weights_t;          // Same order as window_t

    typedef logic [$clog2(PIC_SIZE)-1:0]            col_t;
    typedef logic [$clog2(PIC_SIZE * PIC_SIZE)-1:0] res_addr_t;
    typedef logic [$clog2(KERNEL_TAPS)-1:0]         waddr_t;

endpackage

`default_nettype wire
